// ==== Makefile ====
TOP = tb_crop_top

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f build.f

run: compile
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir

// ==== build.f ====
+incdir+.
video_pkg.sv
keys_pkg.sv
crop_if.sv
hcrop_timer.sv
vcrop_timer.sv
crop_adjust.sv
mode_watch.sv
crop_top.sv
tb_raster_gen.sv
tb_crop_top.sv

// ==== crop_adjust.sv ====
// crop offset control
// decodes adjust scancodes with an alt modifier and loads host presets by req/ack
`timescale 1ns/100ps
`include "crop_config.svh"

module crop_adjust (
	input  logic                clk_28,
	input  logic                rst_n,
	input  keys_pkg::scancode_t kbd_data,
	input  keys_pkg::kbd_type_t kbd_type,
	input  logic                kbd_stb,
	input  logic                load_req,
	input  video_pkg::coord_t   preset_left,
	input  video_pkg::coord_t   preset_right,
	input  video_pkg::coord_t   preset_top,
	input  video_pkg::coord_t   preset_bottom,
	output logic                load_ack,
	crop_if.owner               crop
);
	import keys_pkg::*;
	import video_pkg::*;

	localparam coord_t HSTEP_C = coord_t'(`HSTEP);
	localparam coord_t VSTEP_C = coord_t'(`VSTEP);

	adj_cmd_t cmd_dec, cmd_q;
	logic     adj_stb, stb_q, key_hit;
	logic     alt;                       // modifier held

	assign adj_stb = kbd_stb & (kbd_type == kbd_type_t'(`ADJ_TYPE));

	always_comb begin
		case (kbd_data)
			`KEY_RESET:                  cmd_dec = ADJ_RESET;
			`KEY_UP:                     cmd_dec = ADJ_UP;
			`KEY_DOWN:                   cmd_dec = ADJ_DOWN;
			`KEY_LEFT:                   cmd_dec = ADJ_LEFT;
			`KEY_RIGHT:                  cmd_dec = ADJ_RIGHT;
			`KEY_ALT_ON0, `KEY_ALT_ON1:   cmd_dec = ADJ_ALT_ON;
			`KEY_ALT_OFF0, `KEY_ALT_OFF1: cmd_dec = ADJ_ALT_OFF;
			default:                     cmd_dec = ADJ_NONE;  // other keys ignored
		endcase
	end

	always_ff @(posedge clk_28) begin
		cmd_q <= cmd_dec;                    // byte stable while strobe high
	end

	always_ff @(posedge clk_28) begin
		if (!rst_n) begin
			stb_q                  <= 1'b0;
			key_hit                <= 1'b0;
			alt                    <= 1'b0;
			load_ack               <= 1'b0;
			crop.crop_left         <= '0;
			crop.crop_right        <= '0;
			crop.crop_top_lines    <= '0;
			crop.crop_bottom_lines <= '0;
		end else begin
			stb_q    <= adj_stb;
			key_hit  <= adj_stb & ~stb_q;      // one command per strobe rise
			load_ack <= load_req;              // ack follows req one cycle later

			if (key_hit) begin
				case (cmd_q)
					ADJ_RESET: begin
						crop.crop_left         <= '0;
						crop.crop_right        <= '0;
						crop.crop_top_lines    <= '0;
						crop.crop_bottom_lines <= '0;
					end
					ADJ_UP: begin
						if (alt)
							crop.crop_bottom_lines <= crop.crop_bottom_lines + VSTEP_C;
						else
							crop.crop_top_lines <= crop.crop_top_lines + VSTEP_C;
					end
					ADJ_DOWN: begin
						if (alt)
							crop.crop_bottom_lines <= crop.crop_bottom_lines - VSTEP_C;
						else
							crop.crop_top_lines <= crop.crop_top_lines - VSTEP_C;
					end
					ADJ_LEFT: begin
						if (alt)
							crop.crop_right <= crop.crop_right + HSTEP_C;
						else
							crop.crop_left <= crop.crop_left + HSTEP_C;
					end
					ADJ_RIGHT: begin
						if (alt)
							crop.crop_right <= crop.crop_right - HSTEP_C;
						else
							crop.crop_left <= crop.crop_left - HSTEP_C;
					end
					ADJ_ALT_ON:  alt <= 1'b1;
					ADJ_ALT_OFF: alt <= 1'b0;
					default: ;
				endcase
			end

			// new request, copy presets; overrides a key in the same cycle
			if (load_req && !load_ack) begin
				crop.crop_left         <= preset_left;
				crop.crop_right        <= preset_right;
				crop.crop_top_lines    <= preset_top;
				crop.crop_bottom_lines <= preset_bottom;
			end
		end
	end

endmodule

// ==== crop_config.svh ====
// crop block configuration
// counter widths, adjust steps, blank margins and adjust channel scancodes
`ifndef CROP_CONFIG_SVH
`define CROP_CONFIG_SVH

//////////////////////////////
// widths
`define COORD_W      12       // pixel and line counters, crop offsets
`define MODE_SEQ_W   7        // geometry change counter

//////////////////////////////
// adjust steps and blank margins
`define HSTEP        4        // pixels per left/right press
`define VSTEP        1        // lines per up/down press
`define FHBL_START   8        // forced hblank ends here
`define FHBL_BACK    8        // forced hblank starts this far before line end
`define FVBL_START   1        // forced vblank ends on this line
`define FVBL_BACK    3        // forced vblank starts this many lines before frame end
`define SOFT_H_LEAD  2        // soft hblank lead, covers the output pipeline
`define SOFT_V_LEAD  1

//////////////////////////////
// adjust channel
`define ADJ_TYPE     3        // kbd_type of the adjust channel
`define KEY_RESET    8'h41    // backspace
`define KEY_UP       8'h4c
`define KEY_DOWN     8'h4d
`define KEY_LEFT     8'h4f
`define KEY_RIGHT    8'h4e
`define KEY_ALT_ON0  8'h64    // left alt press
`define KEY_ALT_ON1  8'h65    // right alt press
`define KEY_ALT_OFF0 8'he4    // release codes
`define KEY_ALT_OFF1 8'he5

`endif

// ==== crop_if.sv ====
// crop offset bundle
// the four user crop offsets from the adjust block to the h and v timers
`timescale 1ns/100ps

interface crop_if;
	import video_pkg::*;

	coord_t crop_left;          // pixels cut after hblank end
	coord_t crop_right;         // shift of soft hblank start
	coord_t crop_top_lines;     // lines cut after vblank end
	coord_t crop_bottom_lines;  // shift of soft vblank start

	modport owner (
		output crop_left,
		output crop_right,
		output crop_top_lines,
		output crop_bottom_lines
	);

	modport user (
		input crop_left,
		input crop_right,
		input crop_top_lines,
		input crop_bottom_lines
	);

endinterface

// ==== crop_top.sv ====
// video crop and blanking top
// raster measurement, crop adjust and display enable with geometry report
`timescale 1ns/100ps
`include "crop_config.svh"

module crop_top (
	input  logic                   clk_28,
	input  logic                   rst_n,
	input  logic                   hs,
	input  logic                   vs,
	input  logic                   hblank,
	input  logic                   vblank,
	input  logic                   field1,
	input  video_pkg::res_t        res,
	input  keys_pkg::scancode_t    kbd_data,
	input  keys_pkg::kbd_type_t    kbd_type,
	input  logic                   kbd_stb,
	input  logic                   load_req,
	input  video_pkg::coord_t      preset_left,
	input  video_pkg::coord_t      preset_right,
	input  video_pkg::coord_t      preset_top,
	input  video_pkg::coord_t      preset_bottom,
	output logic                   de,
	output logic                   load_ack,
	output video_pkg::coord_t      crop_left,
	output video_pkg::coord_t      crop_right,
	output video_pkg::coord_t      crop_top_lines,
	output video_pkg::coord_t      crop_bottom_lines,
	output video_pkg::coord_t      hsize,
	output video_pkg::coord_t      vsize,
	output video_pkg::res_t        geom_res,
	output logic [`MODE_SEQ_W-1:0] mode_seq
);
	import video_pkg::*;

	logic   hbl, hde;                    // line blank and registered enable
	logic   first_line, vblank_any;
	coord_t meas_hsize, meas_vsize;      // live measurements
	geom_t  geom;                        // frame-start snapshot

	crop_if i_crop_if ();

	crop_adjust i_adjust (
		.clk_28        (clk_28),
		.rst_n         (rst_n),
		.kbd_data      (kbd_data),
		.kbd_type      (kbd_type),
		.kbd_stb       (kbd_stb),
		.load_req      (load_req),
		.preset_left   (preset_left),
		.preset_right  (preset_right),
		.preset_top    (preset_top),
		.preset_bottom (preset_bottom),
		.load_ack      (load_ack),
		.crop          (i_crop_if.owner)
	);

	hcrop_timer i_htimer (
		.clk_28     (clk_28),
		.rst_n      (rst_n),
		.hs         (hs),
		.hblank     (hblank),
		.first_line (first_line),
		.crop       (i_crop_if.user),
		.hbl        (hbl),
		.hde        (hde),
		.hsize      (meas_hsize)
	);

	vcrop_timer i_vtimer (
		.clk_28     (clk_28),
		.rst_n      (rst_n),
		.vs         (vs),
		.vblank     (vblank),
		.field1     (field1),
		.hs         (hs),
		.hbl        (hbl),
		.hde        (hde),
		.crop       (i_crop_if.user),
		.first_line (first_line),
		.vblank_any (vblank_any),
		.vsize      (meas_vsize),
		.de         (de)
	);

	mode_watch i_mode (
		.clk_28     (clk_28),
		.rst_n      (rst_n),
		.vblank_any (vblank_any),
		.hsize      (meas_hsize),
		.vsize      (meas_vsize),
		.res        (res),
		.geom       (geom),
		.mode_seq   (mode_seq)
	);

	// offsets out for the host
	assign crop_left         = i_crop_if.crop_left;
	assign crop_right        = i_crop_if.crop_right;
	assign crop_top_lines    = i_crop_if.crop_top_lines;
	assign crop_bottom_lines = i_crop_if.crop_bottom_lines;

	// snapshot split into plain ports
	assign hsize    = geom.hsize;
	assign vsize    = geom.vsize;
	assign geom_res = geom.res;

endmodule

// ==== hcrop_timer.sv ====
// horizontal crop timer
// measures the line from hsync and hblank, builds soft and forced line blank
`timescale 1ns/100ps
`include "crop_config.svh"

module hcrop_timer (
	input  logic              clk_28,
	input  logic              rst_n,
	input  logic              hs,          // active low
	input  logic              hblank,
	input  logic              first_line,  // first active line of field 0
	crop_if.user              crop,
	output logic              hbl,         // full line blank
	output logic              hde,
	output video_pkg::coord_t hsize
);
	import video_pkg::*;

	coord_t hcnt;                     // pixel position from hsync
	coord_t hend, hsta, hmax;         // blank end, blank start, line length
	coord_t shbl_off, shbl_on;
	coord_t fhbl_on;
	logic   old_hs, old_hblank;
	logic   hs_fall, hblank_rise, hblank_fall;
	logic   shbl, fhbl;               // soft and forced blank

	assign hs_fall     = old_hs & ~hs;
	assign hblank_rise = ~old_hblank & hblank;
	assign hblank_fall = old_hblank & ~hblank;

	// soft blank edges follow the crop offsets
	assign shbl_off = hend + crop.crop_left - coord_t'(`SOFT_H_LEAD);
	assign shbl_on  = hsta + crop.crop_right - coord_t'(`SOFT_H_LEAD);
	assign fhbl_on  = hmax - coord_t'(`FHBL_BACK);

	assign hbl = fhbl | shbl | ~hs;  // sync always blanks

	always_ff @(posedge clk_28) begin
		if (!rst_n) begin
			old_hs     <= 1'b1;
			old_hblank <= 1'b0;
			hcnt       <= '0;
			hend       <= '0;
			hsta       <= '0;
			hmax       <= '0;
			shbl       <= 1'b1;
			fhbl       <= 1'b1;
			hsize      <= '0;
			hde        <= 1'b0;
		end else begin
			old_hs     <= hs;
			old_hblank <= hblank;

			if (!hs)
				hcnt <= '0;                          // held at zero during sync
			else
				hcnt <= hcnt + 1'b1;

			if (hblank_fall) hend <= hcnt;         // first active pixel
			if (hblank_rise) hsta <= hcnt;         // first blank pixel
			if (hs_fall)     hmax <= hcnt;         // whole line

			if (hcnt == shbl_off) shbl <= 1'b0;
			if (hcnt == shbl_on)  shbl <= 1'b1;    // start wins on a tie

			// forced edges hide the line ends
			if (hcnt == coord_t'(`FHBL_START)) fhbl <= 1'b0;
			if (hcnt == fhbl_on)               fhbl <= 1'b1;

			if (hblank_rise && first_line)
				hsize <= hcnt - hend;                // active run of the first line

			hde <= ~hbl;
		end
	end

endmodule

// ==== keys_pkg.sv ====
// keyboard side types
// raw scancode and type bytes and the decoded crop adjust command

package keys_pkg;

	typedef logic [7:0] scancode_t;  // one keyboard byte
	typedef logic [1:0] kbd_type_t;  // selects keyboard, mouse or adjust data

	// crop adjust commands after decode
	typedef enum logic [2:0] {
		ADJ_NONE,
		ADJ_RESET,    // all offsets to zero
		ADJ_UP,
		ADJ_DOWN,
		ADJ_LEFT,
		ADJ_RIGHT,
		ADJ_ALT_ON,   // modifier moves bottom/right instead
		ADJ_ALT_OFF
	} adj_cmd_t;

endpackage

// ==== mode_watch.sv ====
// geometry monitor
// snapshots the frame geometry at frame start and counts mode changes
`timescale 1ns/100ps
`include "crop_config.svh"

module mode_watch (
	input  logic                  clk_28,
	input  logic                  rst_n,
	input  logic                  vblank_any,
	input  video_pkg::coord_t     hsize,
	input  video_pkg::coord_t     vsize,
	input  video_pkg::res_t       res,
	output video_pkg::geom_t      geom,
	output logic [`MODE_SEQ_W-1:0] mode_seq
);
	import video_pkg::*;

	geom_t geom_now;                     // live measurement
	logic  old_vbl;
	logic  frame_start;

	assign geom_now    = {hsize, vsize, res};
	assign frame_start = old_vbl & ~vblank_any;

	always_ff @(posedge clk_28) begin
		if (!rst_n) begin
			old_vbl  <= 1'b0;
			geom     <= '0;
			mode_seq <= '0;
		end else begin
			old_vbl <= vblank_any;
			if (frame_start) begin
				geom <= geom_now;
				if (geom != geom_now)
					mode_seq <= mode_seq + 1'b1;  // count only real changes
			end
		end
	end

endmodule

// ==== tb_crop_top.sv ====
// crop block testbench
// keyboard adjust, preset handshake, geometry report and enable width checks
`timescale 1ns/100ps
`include "crop_config.svh"

module tb_crop_top;
	import video_pkg::*;
	import keys_pkg::*;

	localparam int LINE_LEN    = 100;
	localparam int FRAME_LINES = 30;
	localparam int VACT_START  = 5;
	localparam int FRAME_CYC   = LINE_LEN * FRAME_LINES;
	localparam int N_FRAMES    = 20;  // generous frame budget for all tests

	logic      clk_28, rst_n;
	logic      hs, vs, hblank, vblank, field1;
	res_t      res;
	scancode_t kbd_data;
	kbd_type_t kbd_type;
	logic      kbd_stb, load_req;
	coord_t    preset_left, preset_right, preset_top, preset_bottom;
	logic      de, load_ack;
	coord_t    crop_left, crop_right, crop_top_lines, crop_bottom_lines;
	coord_t    hsize, vsize, act_width, pix_no, line_no;
	res_t      geom_res;
	logic [`MODE_SEQ_W-1:0] mode_seq;

	int errors, tests, rst_cnt;

	crop_top i_dut (.*);

	tb_raster_gen #(.LINE_LEN(LINE_LEN), .FRAME_LINES(FRAME_LINES),
		.VACT_START(VACT_START)) i_gen (.*);

	//////////////////////////////
	// clock, reset count, watchdog
	initial begin
		clk_28 = 1'b0;
		forever #5 clk_28 = ~clk_28;
	end

	always @(posedge clk_28) begin
		if (!rst_n) rst_cnt <= rst_cnt + 1;  // edges seen in reset
	end

	initial begin
		#((FRAME_CYC * N_FRAMES + 2000) * 10);
		$display("watchdog expired, run did not finish in time");
		$display("Done: errors found");
		$finish;
	end

	task automatic log_error(input string msg);
		errors++;
		$display("%s", msg);
	endtask

	//////////////////////////////
	// concurrent checks
	assert property (@(posedge clk_28) (rst_cnt >= 1 && !rst_n) |->
		(!de && !load_ack && mode_seq == 0 && crop_left == 0 && crop_right == 0
		&& crop_top_lines == 0 && crop_bottom_lines == 0
		&& hsize == 0 && vsize == 0 && geom_res == 0))
		else log_error("outputs not cleared during reset");

	assert property (@(posedge clk_28) disable iff (!rst_n) $rose(load_req) |-> !load_ack)
		else log_error("load_ack already high when load_req rose");
	assert property (@(posedge clk_28) disable iff (!rst_n)
		(load_req && $past(load_req)) |-> load_ack)
		else log_error("load_ack low while load_req held high");
	assert property (@(posedge clk_28) disable iff (!rst_n) $fell(load_req) |=> !load_ack)
		else log_error("load_ack not low one cycle after load_req fell");
	assert property (@(posedge clk_28) disable iff (!rst_n)
		(!load_req && !$past(load_req)) |-> !load_ack)
		else log_error("load_ack high without a request");
	assert property (@(posedge clk_28) disable iff (!rst_n) $rose(load_ack) |->
		(crop_left == preset_left && crop_right == preset_right
		&& crop_top_lines == preset_top && crop_bottom_lines == preset_bottom))
		else log_error("offsets differ from presets at ack");

	//////////////////////////////
	// helpers
	task automatic check_val(input string name, input coord_t got, input coord_t exp);
		assert (got == exp)
		else log_error($sformatf("ERR %s got %h exp %h", name, got, exp));
	endtask

	task automatic send_key(input scancode_t code, input kbd_type_t typ);
		@(negedge clk_28);
		kbd_data = code;
		kbd_type = typ;
		kbd_stb  = 1'b1;
		repeat (2) @(negedge clk_28);  // offsets settle 2 cycles after the rise
		kbd_stb = 1'b0;
		repeat (2) @(negedge clk_28);
	endtask

	task automatic press(input scancode_t code, input int count);
		repeat (count) send_key(code, kbd_type_t'(`ADJ_TYPE));
	endtask

	task automatic wait_frames(input int n);
		repeat (n) @(negedge vs);
	endtask

	// de-high cycles over one whole line of the frame
	task automatic count_de_line(input int target, output int cnt);
		cnt = 0;
		do @(posedge clk_28);
		while (!(line_no == coord_t'(target) && pix_no == 0));
		repeat (LINE_LEN) begin
			@(negedge clk_28);
			if (de) cnt++;
		end
	endtask

	task automatic end_test(input string name, input int err_before);
		tests++;
		$display("test %s: %s", name, (errors == err_before) ? "ok" : "failed");
	endtask

	//////////////////////////////
	// stimulus
	initial begin
		int n, m, k, e0, base, cnt, i;
		logic [`MODE_SEQ_W-1:0] seq0;

		void'($urandom(32'hec869983));
		errors = 0;
		tests = 0;
		rst_cnt = 0;
		rst_n = 1'b0;
		res = 2'd2;
		kbd_data = '0;
		kbd_type = '0;
		kbd_stb = 1'b0;
		load_req = 1'b0;
		preset_left = '0;
		preset_right = '0;
		preset_top = '0;
		preset_bottom = '0;
		act_width = coord_t'(60);

		// reset
		e0 = errors;
		repeat (8) @(posedge clk_28);
		@(negedge clk_28);
		rst_n = 1'b1;
		@(negedge clk_28);
		check_val("de", coord_t'(de), '0);
		check_val("load_ack", coord_t'(load_ack), '0);
		check_val("mode_seq", coord_t'(mode_seq), '0);
		check_val("crop_left", crop_left, '0);
		check_val("crop_top_lines", crop_top_lines, '0);
		end_test("reset", e0);

		// keyboard adjust
		e0 = errors;
		n = 1 + int'($urandom % 5);
		m = 1 + int'($urandom % 5);
		press(`KEY_UP, n);
		press(`KEY_LEFT, m);
		check_val("crop_top_lines", crop_top_lines, coord_t'(n * `VSTEP));
		check_val("crop_left", crop_left, coord_t'(m * `HSTEP));
		press(`KEY_ALT_ON0, 1);
		press(`KEY_UP, n);
		press(`KEY_LEFT, m);
		check_val("crop_bottom_lines", crop_bottom_lines, coord_t'(n * `VSTEP));
		check_val("crop_right", crop_right, coord_t'(m * `HSTEP));
		check_val("crop_top_lines", crop_top_lines, coord_t'(n * `VSTEP));
		press(`KEY_ALT_OFF0, 1);
		press(`KEY_RESET, 1);
		check_val("crop_left", crop_left, '0);
		check_val("crop_right", crop_right, '0);
		check_val("crop_top_lines", crop_top_lines, '0);
		check_val("crop_bottom_lines", crop_bottom_lines, '0);
		send_key(`KEY_UP, kbd_type_t'(0));   // keyboard data, not adjust
		send_key(`KEY_LEFT, kbd_type_t'(1));
		check_val("crop_top_lines", crop_top_lines, '0);
		check_val("crop_left", crop_left, '0);
		end_test("keyboard", e0);

		// preset handshake
		e0 = errors;
		@(negedge clk_28);
		preset_left = coord_t'(12);
		preset_right = coord_t'(8);
		preset_top = coord_t'(2);
		preset_bottom = coord_t'(3);
		@(negedge clk_28);
		load_req = 1'b1;
		i = 0;
		while (!load_ack && i < 16) begin
			@(negedge clk_28);
			i++;
		end
		if (!load_ack) log_error("load_ack never rose after load_req");
		repeat (3) @(negedge clk_28);
		load_req = 1'b0;
		i = 0;
		while (load_ack && i < 16) begin
			@(negedge clk_28);
			i++;
		end
		if (load_ack) log_error("load_ack never fell after load_req");
		check_val("crop_left", crop_left, coord_t'(12));
		check_val("crop_bottom_lines", crop_bottom_lines, coord_t'(3));
		press(`KEY_RESET, 1);
		end_test("preset", e0);

		// geometry report
		e0 = errors;
		wait_frames(3);
		check_val("hsize", hsize, coord_t'(60));
		check_val("vsize", vsize, coord_t'(20));
		check_val("geom_res", coord_t'(geom_res), coord_t'(res));
		seq0 = mode_seq;
		wait_frames(2);
		check_val("mode_seq", coord_t'(mode_seq), coord_t'(seq0));
		act_width = coord_t'(56);            // set at a frame boundary
		wait_frames(3);
		check_val("hsize", hsize, coord_t'(56));
		check_val("mode_seq", coord_t'(mode_seq), coord_t'(seq0 + 1'b1));
		end_test("geometry", e0);

		// crop effect on enable width
		e0 = errors;
		count_de_line(VACT_START + 8, base);
		if (base == 0) log_error("no enable seen on an active line");
		k = 1 + int'($urandom % 4);
		press(`KEY_LEFT, k);
		wait_frames(2);
		count_de_line(VACT_START + 8, cnt);
		check_val("de_count", coord_t'(cnt), coord_t'(base - k * `HSTEP));
		press(`KEY_RESET, 1);
		end_test("crop_enable", e0);

		$display("tests %0d errors %0d", tests, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// ==== tb_raster_gen.sv ====
// testbench raster source
// progressive frame with sync, blanking and a run-time active width
`timescale 1ns/100ps

module tb_raster_gen #(
	parameter int LINE_LEN    = 100,  // pixels per line
	parameter int HS_W        = 8,    // hsync pixels
	parameter int ACT_START   = 20,   // first active pixel
	parameter int FRAME_LINES = 30,
	parameter int VS_LINES    = 2,
	parameter int VACT_START  = 5,    // first active line
	parameter int ACT_LINES   = 20
) (
	input  logic              clk_28,
	input  logic              rst_n,
	input  video_pkg::coord_t act_width,  // may change between frames
	output logic              hs,
	output logic              vs,
	output logic              hblank,
	output logic              vblank,
	output logic              field1,
	output video_pkg::coord_t pix_no,
	output video_pkg::coord_t line_no
);
	import video_pkg::*;

	int h, v;

	assign field1  = 1'b0;             // progressive only
	assign pix_no  = coord_t'(h);
	assign line_no = coord_t'(v);

	// sync and blank follow the position directly
	assign hs     = !(h < HS_W);
	assign vs     = !(v < VS_LINES);
	assign hblank = !(h >= ACT_START && h < ACT_START + int'(act_width));
	assign vblank = !(v >= VACT_START && v < VACT_START + ACT_LINES);

	// position moves on the falling edge
	always @(negedge clk_28) begin
		if (!rst_n) begin
			h <= 0;
			v <= 0;
		end else if (h == LINE_LEN - 1) begin
			h <= 0;
			v <= (v == FRAME_LINES - 1) ? 0 : v + 1;  // wrap at frame end
		end else begin
			h <= h + 1;
		end
	end

endmodule

// ==== vcrop_timer.sv ====
// vertical crop timer
// counts lines, measures blank per field, builds vertical blank and display enable
`timescale 1ns/100ps
`include "crop_config.svh"

module vcrop_timer (
	input  logic              clk_28,
	input  logic              rst_n,
	input  logic              vs,          // active low
	input  logic              vblank,
	input  logic              field1,
	input  logic              hs,          // active low
	input  logic              hbl,
	input  logic              hde,
	crop_if.user              crop,
	output logic              first_line,
	output logic              vblank_any,
	output video_pkg::coord_t vsize,
	output logic              de
);
	import video_pkg::*;

	coord_t vcnt;                        // line number from vsync
	coord_t vend, vsta, vmax;            // field 0 measurements
	coord_t f1_vend, f1_vsize;           // field 1 measurements
	coord_t svbl_off, svbl_on, fvbl_on;
	logic   old_vs, old_hs, old_vbl, old_hbl;
	logic   vs_fall, hs_fall, vbl_rise, vbl_fall, hbl_fall;
	logic   svbl, fvbl;

	assign vblank_any = vblank | ~vs;

	assign vs_fall  = old_vs & ~vs;
	assign hs_fall  = old_hs & ~hs;
	assign vbl_rise = ~old_vbl & vblank_any;
	assign vbl_fall = old_vbl & ~vblank_any;
	assign hbl_fall = old_hbl & ~hbl;

	assign svbl_off = vend + crop.crop_top_lines - coord_t'(`SOFT_V_LEAD);
	assign svbl_on  = vsta + crop.crop_bottom_lines - coord_t'(`SOFT_V_LEAD);
	assign fvbl_on  = vmax - coord_t'(`FVBL_BACK);

	// vend is the count before the line step at blank end
	assign first_line = ~field1 & ~vblank_any & (vcnt == vend + 1'b1);
	assign de         = hde & ~(fvbl | svbl);

	always_ff @(posedge clk_28) begin
		if (!rst_n) begin
			old_vs   <= 1'b1;
			old_hs   <= 1'b1;
			old_vbl  <= 1'b0;
			old_hbl  <= 1'b0;
			vcnt     <= '0;
			vend     <= '0;
			vsta     <= '0;
			vmax     <= '0;
			f1_vend  <= '0;
			f1_vsize <= '0;
			vsize    <= '0;
			svbl     <= 1'b1;
			fvbl     <= 1'b1;
		end else begin
			old_vs  <= vs;
			old_hs  <= hs;
			old_vbl <= vblank_any;
			old_hbl <= hbl;

			if (!vs)
				vcnt <= '0;
			else if (hs_fall)
				vcnt <= vcnt + 1'b1;                 // one per line

			if (!field1) begin
				if (vbl_fall) vend <= vcnt;
				if (vbl_rise) vsta <= vcnt;
				if (vs_fall)  vmax <= vcnt;          // frame length in lines
				if (vbl_rise) begin
					vsize    <= vcnt - vend + f1_vsize;  // both fields
					f1_vsize <= '0;
				end
			end else begin
				if (vbl_fall) f1_vend  <= vcnt;
				if (vbl_rise) f1_vsize <= vcnt - f1_vend;
			end

			// blank state moves only at line start
			if (hbl_fall) begin
				if (vcnt == svbl_off) svbl <= 1'b0;
				if (vcnt == svbl_on)  svbl <= 1'b1;
				if (vcnt == coord_t'(`FVBL_START)) fvbl <= 1'b0;
				if (vcnt == fvbl_on)               fvbl <= 1'b1;
			end
		end
	end

endmodule

// ==== video_pkg.sv ====
// raster types
// coordinates, resolution code and the measured frame geometry
`include "crop_config.svh"

package video_pkg;

	//////////////////////////////
	// scalar types
	typedef logic [`COORD_W-1:0] coord_t;  // pixel or line count
	typedef logic [1:0]          res_t;    // resolution code from the video source

	//////////////////////////////
	// frame geometry, 26 bits
	typedef struct packed {
		coord_t hsize;  // active pixels per line
		coord_t vsize;  // active lines, both fields
		res_t   res;
	} geom_t;

endpackage
